// File: exu_pkg.sv
/*
 Shared types for the RV32I execute pipeline. Every stage imports the
 unit groups, the operation encodings and the per-group decode-info word
*/
package exu_pkg;

    typedef enum logic [2:0] {
        GRP_ALU, GRP_BJP, GRP_MEM, GRP_SYS, GRP_ILLEGAL
    } grp_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [2:0] {
        BJP_JAL, BJP_JALR, BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU
    } bjp_op_e;

    typedef enum logic [2:0] {
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        SYS_NOP, SYS_FENCE, SYS_ECALL, SYS_EBREAK, SYS_MRET
    } sys_op_e;

    // Views of the 8-bit info word padded to the same width
    typedef struct packed {
        logic [2:0] pad;
        logic       op2_imm;  // Immediate replaces rs2
        alu_op_e    op;
    } alu_info_t;

    typedef struct packed {
        logic [4:0] pad;
        bjp_op_e    op;
    } bjp_info_t;

    typedef struct packed {
        logic [3:0] pad;
        logic       is_store;
        mem_op_e    op;
    } mem_info_t;

    typedef struct packed {
        logic [4:0] pad;
        sys_op_e    op;
    } sys_info_t;

    // Read through the view that matches grp_e
    typedef union packed {
        alu_info_t alu;
        bjp_info_t bjp;
        mem_info_t mem;
        sys_info_t sys;
    } dec_info_u;

    typedef enum logic [2:0] {
        UNIT_ADDER, UNIT_SHIFTER, UNIT_BJP, UNIT_MEM, UNIT_NONE
    } unit_e;

endpackage

// File: dec_if.sv
/*
 Decode to dispatch stream. Transfer on a rising edge with valid and
 ready high, payload held stable while stalled
*/
`timescale 1ns/1ns

interface dec_if import exu_pkg::*; ();

    logic        valid;
    logic        ready;
    grp_e        grp;
    dec_info_u   info;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    modport src (output valid, grp, info, imm, pc, rs1_val, rs2_val, input ready);
    modport dst (input valid, grp, info, imm, pc, rs1_val, rs2_val, output ready);

endinterface

// File: disp_if.sv
/*
 Dispatch to execute stream carrying the selected unit, its operands
 and the finished memory request fields
*/
`timescale 1ns/1ns

interface disp_if import exu_pkg::*; ();

    logic        valid;
    logic        ready;
    unit_e       unit;
    dec_info_u   info;
    grp_e        grp;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] jump_base;
    logic [31:0] jump_offset;
    logic [31:0] mem_addr;
    logic [ 3:0] mem_wmask;
    logic [31:0] mem_wdata;
    logic        misaligned;

    modport src (output valid, unit, info, grp, op1, op2, jump_base, jump_offset,
                 mem_addr, mem_wmask, mem_wdata, misaligned, input ready);
    modport dst (input valid, unit, info, grp, op1, op2, jump_base, jump_offset,
                 mem_addr, mem_wmask, mem_wdata, misaligned, output ready);

endinterface

// File: decode_stage.sv
/*
 First pipeline stage. Decodes an RV32I word into group, info and
 immediate and holds the result in a single output slot
*/
`timescale 1ns/1ns

module decode_stage import exu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] rs1_val_i,
    input  logic [31:0] rs2_val_i,
    dec_if.src          dec_o
);

    logic [ 6:0] opcode;
    logic [ 2:0] funct3;
    logic [ 6:0] funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    alu_op_e     alu_op;
    logic        alu_ok;
    grp_e        grp;
    dec_info_u   info;
    logic [31:0] imm;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'h000};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // OP and OP-IMM share funct3; opcode[5] marks the register form
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode[5] && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    assign alu_ok = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                                              (opcode[5] && funct3 == 3'b000))) ||
                    (!opcode[5] && funct3 != 3'b001 && funct3 != 3'b101);

    always_comb begin
        grp  = GRP_ILLEGAL;
        info = '0;
        imm  = '0;
        case (opcode)
            7'b0110111, 7'b0010111: begin  // LUI, AUIPC
                grp              = GRP_ALU;
                info.alu.op      = opcode[5] ? ALU_LUI : ALU_AUIPC;
                info.alu.op2_imm = 1'b1;
                imm              = imm_u;
            end
            7'b0010011, 7'b0110011: begin
                grp              = alu_ok ? GRP_ALU : GRP_ILLEGAL;
                info.alu.op      = alu_op;
                info.alu.op2_imm = !opcode[5];
                imm              = imm_i;
            end
            7'b1101111: begin
                grp         = GRP_BJP;
                info.bjp.op = BJP_JAL;
                imm         = imm_j;
            end
            7'b1100111: begin
                grp         = (funct3 == 3'b000) ? GRP_BJP : GRP_ILLEGAL;
                info.bjp.op = BJP_JALR;
                imm         = imm_i;
            end
            7'b1100011: begin
                grp = GRP_BJP;
                imm = imm_b;
                case (funct3)
                    3'b000:  info.bjp.op = BJP_BEQ;
                    3'b001:  info.bjp.op = BJP_BNE;
                    3'b100:  info.bjp.op = BJP_BLT;
                    3'b101:  info.bjp.op = BJP_BGE;
                    3'b110:  info.bjp.op = BJP_BLTU;
                    3'b111:  info.bjp.op = BJP_BGEU;
                    default: grp = GRP_ILLEGAL;
                endcase
            end
            7'b0000011: begin
                grp = GRP_MEM;
                imm = imm_i;
                case (funct3)
                    3'b000:  info.mem.op = MEM_LB;
                    3'b001:  info.mem.op = MEM_LH;
                    3'b010:  info.mem.op = MEM_LW;
                    3'b100:  info.mem.op = MEM_LBU;
                    3'b101:  info.mem.op = MEM_LHU;
                    default: grp = GRP_ILLEGAL;
                endcase
            end
            7'b0100011: begin
                grp               = (funct3 < 3'b011) ? GRP_MEM : GRP_ILLEGAL;
                info.mem.is_store = 1'b1;
                info.mem.op       = (funct3 == 3'b000) ? MEM_SB :
                                    (funct3 == 3'b001) ? MEM_SH : MEM_SW;
                imm               = imm_s;
            end
            7'b0001111: begin
                // FENCE.I has nothing to flush here
                grp         = (funct3 < 3'b010) ? GRP_SYS : GRP_ILLEGAL;
                info.sys.op = funct3[0] ? SYS_NOP : SYS_FENCE;
            end
            7'b1110011: begin
                grp = GRP_SYS;
                case (instr_i)
                    32'h0000_0073: info.sys.op = SYS_ECALL;
                    32'h0010_0073: info.sys.op = SYS_EBREAK;
                    32'h3020_0073: info.sys.op = SYS_MRET;
                    default:       grp = GRP_ILLEGAL;
                endcase
            end
            default: grp = GRP_ILLEGAL;
        endcase
    end

    assign in_ready_o = !dec_o.valid || dec_o.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
        end else if (in_ready_o) begin
            dec_o.valid <= in_valid_i;  // Slot free or draining
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            dec_o.grp     <= grp;
            dec_o.info    <= info;
            dec_o.imm     <= imm;
            dec_o.pc      <= pc_i;
            dec_o.rs1_val <= rs1_val_i;
            dec_o.rs2_val <= rs2_val_i;
        end
    end

endmodule

// File: dispatch_logic.sv
/*
 Second pipeline stage. Picks the functional unit and its operands, and
 builds the memory address, store lanes and misalignment flag
*/
`timescale 1ns/1ns

module dispatch_logic import exu_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    dec_if.dst   dec_i,
    disp_if.src  disp_o
);

    logic        op_alu;
    logic        op_bjp;
    logic        op_mem;
    logic        is_jalr;
    logic        is_jump;
    unit_e       unit;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] jump_base;
    logic [31:0] jump_offset;
    logic [31:0] addr;
    logic [ 3:0] wmask;
    logic [31:0] wdata;
    logic        misaligned;

    assign op_alu  = (dec_i.grp == GRP_ALU);
    assign op_bjp  = (dec_i.grp == GRP_BJP);
    assign op_mem  = (dec_i.grp == GRP_MEM);
    assign is_jalr = op_bjp && (dec_i.info.bjp.op == BJP_JALR);
    assign is_jump = is_jalr || (op_bjp && dec_i.info.bjp.op == BJP_JAL);

    always_comb begin
        unit = UNIT_NONE;
        op1  = '0;
        op2  = '0;
        if (op_alu) begin
            case (dec_i.info.alu.op)
                ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_AND, ALU_OR, ALU_XOR: unit = UNIT_SHIFTER;
                default:                  unit = UNIT_ADDER;
            endcase
            op1 = (dec_i.info.alu.op == ALU_LUI)   ? 32'h0    :
                  (dec_i.info.alu.op == ALU_AUIPC) ? dec_i.pc : dec_i.rs1_val;
            op2 = dec_i.info.alu.op2_imm ? dec_i.imm : dec_i.rs2_val;
        end else if (op_bjp) begin
            unit = UNIT_BJP;
            // Jumps reuse the adder for the link value pc + 4
            op1  = is_jump ? dec_i.pc : dec_i.rs1_val;
            op2  = is_jump ? 32'd4    : dec_i.rs2_val;
        end else if (op_mem) begin
            unit = UNIT_MEM;
        end
    end

    assign jump_base   = is_jalr ? dec_i.rs1_val : op_bjp ? dec_i.pc : 32'h0;
    assign jump_offset = op_bjp ? dec_i.imm : 32'h0;

    assign addr = op_mem ? dec_i.rs1_val + dec_i.imm : 32'h0;

    // Store lanes follow addr[1:0]; loads leave mask and data at zero
    always_comb begin
        wmask      = 4'b0000;
        wdata      = '0;
        misaligned = 1'b0;
        if (op_mem) begin
            case (dec_i.info.mem.op)
                MEM_SB: begin
                    wmask = 4'b0001 << addr[1:0];
                    wdata = {24'h0, dec_i.rs2_val[7:0]} << {addr[1:0], 3'b000};
                end
                MEM_SH: begin
                    wmask      = addr[1] ? 4'b1100 : 4'b0011;
                    wdata      = addr[1] ? {dec_i.rs2_val[15:0], 16'h0} :
                                           {16'h0, dec_i.rs2_val[15:0]};
                    misaligned = addr[0];
                end
                MEM_SW: begin
                    wmask      = 4'b1111;
                    wdata      = dec_i.rs2_val;
                    misaligned = |addr[1:0];
                end
                MEM_LH, MEM_LHU: misaligned = addr[0];
                MEM_LW:          misaligned = |addr[1:0];
                MEM_LB, MEM_LBU: misaligned = 1'b0;  // Any byte address is fine
                default:         misaligned = 1'b0;
            endcase
        end
    end

    assign dec_i.ready = !disp_o.valid || disp_o.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            disp_o.valid <= 1'b0;
        end else if (dec_i.ready) begin
            disp_o.valid <= dec_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_i.valid && dec_i.ready) begin
            disp_o.unit        <= unit;
            disp_o.info        <= dec_i.info;
            disp_o.grp         <= dec_i.grp;
            disp_o.op1         <= op1;
            disp_o.op2         <= op2;
            disp_o.jump_base   <= jump_base;
            disp_o.jump_offset <= jump_offset;
            disp_o.mem_addr    <= addr;
            disp_o.mem_wmask   <= wmask;
            disp_o.mem_wdata   <= wdata;
            disp_o.misaligned  <= misaligned;
        end
    end

endmodule

// File: exec_stage.sv
/*
 Last pipeline stage. Runs the adder, shifter and branch units and
 registers write-back, branch and memory request results
*/
`timescale 1ns/1ns

module exec_stage import exu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    disp_if.dst         disp_i,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output logic        rd_we_o,
    output logic [31:0] rd_wdata_o,
    output logic        br_taken_o,
    output logic [31:0] br_target_o,
    output logic        mem_req_o,
    output logic        mem_we_o,
    output logic [31:0] mem_addr_o,
    output logic [ 3:0] mem_wmask_o,
    output logic [31:0] mem_wdata_o,
    output logic        misaligned_o,
    output logic        illegal_o
);

    logic [31:0] sum;
    logic [32:0] diff;
    logic        lt;
    logic        ltu;
    logic [31:0] adder_res;
    logic [31:0] shift_res;
    logic        is_bjp;
    logic        is_jalr;
    logic        is_jump;
    logic        taken;
    logic [31:0] target;
    logic [31:0] wb_data;
    logic        wb_en;
    logic        req;

    assign sum  = disp_i.op1 + disp_i.op2;
    assign diff = {1'b0, disp_i.op1} - {1'b0, disp_i.op2};
    assign ltu  = diff[32];  // Borrow out
    assign lt   = (disp_i.op1[31] != disp_i.op2[31]) ? disp_i.op1[31] : diff[31];

    always_comb begin
        case (disp_i.info.alu.op)
            ALU_SUB:  adder_res = diff[31:0];
            ALU_SLT:  adder_res = {31'h0, lt};
            ALU_SLTU: adder_res = {31'h0, ltu};
            default:  adder_res = sum;  // ADD, LUI, AUIPC
        endcase
    end

    always_comb begin
        case (disp_i.info.alu.op)
            ALU_SLL: shift_res = disp_i.op1 << disp_i.op2[4:0];
            ALU_SRL: shift_res = disp_i.op1 >> disp_i.op2[4:0];
            ALU_SRA: shift_res = $signed(disp_i.op1) >>> disp_i.op2[4:0];
            ALU_AND: shift_res = disp_i.op1 & disp_i.op2;
            ALU_OR:  shift_res = disp_i.op1 | disp_i.op2;
            default: shift_res = disp_i.op1 ^ disp_i.op2;
        endcase
    end

    assign is_bjp  = (disp_i.grp == GRP_BJP);
    assign is_jalr = is_bjp && (disp_i.info.bjp.op == BJP_JALR);
    assign is_jump = is_jalr || (is_bjp && disp_i.info.bjp.op == BJP_JAL);

    always_comb begin
        case (disp_i.info.bjp.op)
            BJP_BEQ:  taken = (disp_i.op1 == disp_i.op2);
            BJP_BNE:  taken = (disp_i.op1 != disp_i.op2);
            BJP_BLT:  taken = lt;
            BJP_BGE:  taken = !lt;
            BJP_BLTU: taken = ltu;
            BJP_BGEU: taken = !ltu;
            default:  taken = 1'b1;  // JAL, JALR
        endcase
        taken = taken && is_bjp;
    end

    // JALR target has bit 0 cleared
    assign target = (disp_i.jump_base + disp_i.jump_offset) & ~{31'h0, is_jalr};

    always_comb begin
        case (disp_i.unit)
            UNIT_ADDER:   wb_data = adder_res;
            UNIT_SHIFTER: wb_data = shift_res;
            UNIT_BJP:     wb_data = is_jump ? sum : 32'h0;
            default:      wb_data = 32'h0;  // Load data returns elsewhere
        endcase
    end

    assign req   = (disp_i.grp == GRP_MEM) && !disp_i.misaligned;
    assign wb_en = (disp_i.grp == GRP_ALU) || is_jump || (req && !disp_i.info.mem.is_store);

    assign disp_i.ready = !out_valid_o || out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (disp_i.ready) begin
            out_valid_o <= disp_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (disp_i.valid && disp_i.ready) begin
            rd_we_o      <= wb_en;
            rd_wdata_o   <= wb_data;
            br_taken_o   <= taken;
            br_target_o  <= is_bjp ? target : 32'h0;
            mem_req_o    <= req;
            mem_we_o     <= req && disp_i.info.mem.is_store;
            mem_addr_o   <= disp_i.mem_addr;
            mem_wmask_o  <= disp_i.mem_wmask;
            mem_wdata_o  <= disp_i.mem_wdata;
            misaligned_o <= disp_i.misaligned;
            illegal_o    <= (disp_i.grp == GRP_ILLEGAL);
        end
    end

endmodule

// File: exu_top.sv
/*
 RV32I execute subsystem top. Chains decode, dispatch and execute with
 valid/ready streams, three cycles from accept to result
*/
`timescale 1ns/1ns

module exu_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] rs1_val_i,
    input  logic [31:0] rs2_val_i,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output logic        rd_we_o,
    output logic [31:0] rd_wdata_o,
    output logic        br_taken_o,
    output logic [31:0] br_target_o,
    output logic        mem_req_o,
    output logic        mem_we_o,
    output logic [31:0] mem_addr_o,
    output logic [ 3:0] mem_wmask_o,
    output logic [31:0] mem_wdata_o,
    output logic        misaligned_o,
    output logic        illegal_o
);

    dec_if  dec_bus ();
    disp_if disp_bus ();

    decode_stage u_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rs1_val_i  (rs1_val_i),
        .rs2_val_i  (rs2_val_i),
        .dec_o      (dec_bus.src)
    );

    dispatch_logic u_dispatch (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dec_i   (dec_bus.dst),
        .disp_o  (disp_bus.src)
    );

    exec_stage u_exec (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .disp_i       (disp_bus.dst),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .rd_we_o      (rd_we_o),
        .rd_wdata_o   (rd_wdata_o),
        .br_taken_o   (br_taken_o),
        .br_target_o  (br_target_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wmask_o  (mem_wmask_o),
        .mem_wdata_o  (mem_wdata_o),
        .misaligned_o (misaligned_o),
        .illegal_o    (illegal_o)
    );

endmodule

// File: tb_exu.sv
/*
 Testbench for the RV32I execute pipeline. Runs a table of instructions
 twice, first with the output always ready, then under LFSR back-pressure
*/
`timescale 1ns/1ns

module tb_exu;

    localparam int TIMEOUT = 200;  // Cycles per wait

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        rd_we;
        logic [31:0] rd_wdata;
        logic        br_taken;
        logic [31:0] br_target;
        logic        mem_req;
        logic        mem_we;
        logic [31:0] mem_addr;
        logic [ 3:0] mem_wmask;
        logic [31:0] mem_wdata;
        logic        misaligned;
        logic        illegal;
    } entry_t;

    logic        clk_i;
    logic        rst_n_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_val_i;
    logic [31:0] rs2_val_i;
    logic        out_valid_o;
    logic        out_ready_i;
    logic        rd_we_o;
    logic [31:0] rd_wdata_o;
    logic        br_taken_o;
    logic [31:0] br_target_o;
    logic        mem_req_o;
    logic        mem_we_o;
    logic [31:0] mem_addr_o;
    logic [ 3:0] mem_wmask_o;
    logic [31:0] mem_wdata_o;
    logic        misaligned_o;
    logic        illegal_o;

    entry_t      tbl [0:63];
    int          n_entries = 0;
    int          accept_cycle [0:127];  // Cycle in which each input was taken
    int          edge_cnt = 0;
    int          checks = 0;
    int          errors = 0;
    logic        bp_on = 1'b0;          // Random out_ready once the first pass is out
    logic [15:0] lfsr;

    exu_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) edge_cnt <= edge_cnt + 1;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Encoders use rd = x1, rs1 = x2 and rs2 = x3
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {imm, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd1, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic add_stim(input logic [31:0] instr, pc, rs1, rs2);
        entry_t e;
        e       = '{default: '0};  // Fields a group does not use read as zero
        e.instr = instr;
        e.pc    = pc;
        e.rs1   = rs1;
        e.rs2   = rs2;
        tbl[n_entries] = e;
        n_entries++;
    endtask

    task automatic alu_entry(input logic [31:0] instr, pc, rs1, rs2, result);
        add_stim(instr, pc, rs1, rs2);
        tbl[n_entries-1].rd_we    = 1'b1;
        tbl[n_entries-1].rd_wdata = result;
    endtask

    // we_taken is {rd_we, br_taken}
    task automatic ctl_entry(input logic [31:0] instr, pc, rs1, rs2,
                             input logic [1:0] we_taken, input logic [31:0] wdata, target);
        add_stim(instr, pc, rs1, rs2);
        tbl[n_entries-1].rd_we     = we_taken[1];
        tbl[n_entries-1].br_taken  = we_taken[0];
        tbl[n_entries-1].rd_wdata  = wdata;
        tbl[n_entries-1].br_target = target;
    endtask

    // flags is {rd_we, mem_req, mem_we, misaligned}
    task automatic mem_entry(input logic [31:0] instr, rs1, rs2, input logic [3:0] flags,
                             input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] data);
        add_stim(instr, 32'h3000, rs1, rs2);
        tbl[n_entries-1].rd_we      = flags[3];
        tbl[n_entries-1].mem_req    = flags[2];
        tbl[n_entries-1].mem_we     = flags[1];
        tbl[n_entries-1].misaligned = flags[0];
        tbl[n_entries-1].mem_addr   = addr;
        tbl[n_entries-1].mem_wmask  = mask;
        tbl[n_entries-1].mem_wdata  = data;
    endtask

    task automatic sys_entry(input logic [31:0] instr, input logic illegal);
        add_stim(instr, 32'h4000, 32'h1234, 32'h5678);
        tbl[n_entries-1].illegal = illegal;
    endtask

    task automatic build_table();
        alu_entry(enc_r(7'h00, 3'd0, OP_REG), 32'h100, 32'h5, 32'h7, 32'hc);
        alu_entry(enc_r(7'h20, 3'd0, OP_REG), 32'h104, 32'h5, 32'h7, 32'hffff_fffe);
        alu_entry(enc_r(7'h00, 3'd2, OP_REG), 32'h108, 32'hffff_ffff, 32'h1, 32'h1);
        alu_entry(enc_r(7'h00, 3'd3, OP_REG), 32'h10c, 32'hffff_ffff, 32'h1, 32'h0);
        alu_entry(enc_r(7'h00, 3'd1, OP_REG), 32'h110, 32'h1, 32'h24, 32'h10);
        alu_entry(enc_r(7'h00, 3'd5, OP_REG), 32'h114, 32'h8000_0000, 32'h4, 32'h0800_0000);
        alu_entry(enc_r(7'h20, 3'd5, OP_REG), 32'h118, 32'h8000_0000, 32'h4, 32'hf800_0000);
        alu_entry(enc_r(7'h00, 3'd7, OP_REG), 32'h11c, 32'hf0f0, 32'hff00, 32'hf000);
        alu_entry(enc_r(7'h00, 3'd6, OP_REG), 32'h120, 32'hf0f0, 32'h0f0f, 32'hffff);
        alu_entry(enc_r(7'h00, 3'd4, OP_REG), 32'h124, 32'hff00_ff00, 32'hffff_ffff,
                  32'h00ff_00ff);
        alu_entry(enc_i(12'hffc, 3'd0, OP_IMM), 32'h128, 32'h10, 32'h55, 32'hc);
        alu_entry(enc_i(12'h408, 3'd5, OP_IMM), 32'h12c, 32'hf000_0000, 32'h0, 32'hfff0_0000);
        alu_entry(enc_u(20'h12345, OP_LUI), 32'h130, 32'h77, 32'h0, 32'h1234_5000);
        alu_entry(enc_u(20'h00001, OP_AUIPC), 32'h2000, 32'h77, 32'h0, 32'h3000);
        // Branch target is pc + imm whether taken or not
        ctl_entry(enc_b(13'h0010, 3'd0), 32'h100, 32'h5, 32'h5, 2'b01, 32'h0, 32'h110);
        ctl_entry(enc_b(13'h0010, 3'd0), 32'h100, 32'h5, 32'h6, 2'b00, 32'h0, 32'h110);
        ctl_entry(enc_b(13'h0010, 3'd1), 32'h100, 32'h5, 32'h5, 2'b00, 32'h0, 32'h110);
        ctl_entry(enc_b(13'h0010, 3'd4), 32'h100, 32'hffff_ffff, 32'h1, 2'b01, 32'h0, 32'h110);
        ctl_entry(enc_b(13'h0010, 3'd5), 32'h100, 32'hffff_ffff, 32'h1, 2'b00, 32'h0, 32'h110);
        ctl_entry(enc_b(13'h0010, 3'd6), 32'h100, 32'hffff_ffff, 32'h1, 2'b00, 32'h0, 32'h110);
        ctl_entry(enc_b(13'h1ff8, 3'd7), 32'h200, 32'hffff_ffff, 32'h1, 2'b01, 32'h0, 32'h1f8);
        ctl_entry(enc_j(21'h000100), 32'h400, 32'h0, 32'h0, 2'b11, 32'h404, 32'h500);
        ctl_entry(enc_j(21'h1ffff0), 32'h400, 32'h0, 32'h0, 2'b11, 32'h404, 32'h3f0);
        ctl_entry(enc_i(12'h005, 3'd0, OP_JALR), 32'h400, 32'h1000, 32'h0, 2'b11, 32'h404,
                  32'h1004);
        // Stores in every lane, then loads
        mem_entry(enc_s(12'h000, 3'd0), 32'h1000, 32'h1122_3344, 4'b0110, 32'h1000, 4'h1,
                  32'h44);
        mem_entry(enc_s(12'h001, 3'd0), 32'h1000, 32'h1122_3344, 4'b0110, 32'h1001, 4'h2,
                  32'h4400);
        mem_entry(enc_s(12'h002, 3'd0), 32'h1000, 32'h1122_3344, 4'b0110, 32'h1002, 4'h4,
                  32'h0044_0000);
        mem_entry(enc_s(12'h003, 3'd0), 32'h1000, 32'h1122_3344, 4'b0110, 32'h1003, 4'h8,
                  32'h4400_0000);
        mem_entry(enc_s(12'h000, 3'd1), 32'h1000, 32'h1122_3344, 4'b0110, 32'h1000, 4'h3,
                  32'h3344);
        mem_entry(enc_s(12'h002, 3'd1), 32'h1000, 32'h1122_3344, 4'b0110, 32'h1002, 4'hc,
                  32'h3344_0000);
        mem_entry(enc_s(12'hffc, 3'd2), 32'h1004, 32'h1122_3344, 4'b0110, 32'h1000, 4'hf,
                  32'h1122_3344);
        mem_entry(enc_i(12'h004, 3'd2, OP_LOAD), 32'h2000, 32'h55, 4'b1100, 32'h2004, 4'h0, 32'h0);
        mem_entry(enc_i(12'h003, 3'd4, OP_LOAD), 32'h2000, 32'h55, 4'b1100, 32'h2003, 4'h0, 32'h0);
        mem_entry(enc_i(12'h002, 3'd1, OP_LOAD), 32'h2000, 32'h55, 4'b1100, 32'h2002, 4'h0, 32'h0);
        // Misaligned accesses drop both the request and the write-back
        mem_entry(enc_i(12'h002, 3'd2, OP_LOAD), 32'h2000, 32'h55, 4'b0001, 32'h2002, 4'h0, 32'h0);
        mem_entry(enc_i(12'h001, 3'd1, OP_LOAD), 32'h2000, 32'h55, 4'b0001, 32'h2001, 4'h0, 32'h0);
        mem_entry(enc_s(12'h001, 3'd2), 32'h1000, 32'h1122_3344, 4'b0001, 32'h1001, 4'hf,
                  32'h1122_3344);
        sys_entry(32'h0ff0_000f, 1'b0);  // FENCE
        sys_entry(32'h0000_0073, 1'b0);  // ECALL
        sys_entry(32'h0000_0000, 1'b1);
        sys_entry(enc_r(7'h01, 3'd0, OP_REG), 1'b1);  // MUL is outside RV32I
        sys_entry(enc_b(13'h0010, 3'd2), 1'b1);
    endtask

    task automatic check_val(input int idx, input string what, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: entry %0d %s got %h expected %h", $time, idx, what, got, exp);
        end
    endtask

    // Output back-pressure
    initial begin
        out_ready_i = 1'b1;
        lfsr        = 16'd69;
        forever begin
            @(negedge clk_i);
            if (bp_on) begin
                lfsr        = lfsr_next(lfsr);
                out_ready_i = lfsr[0];
            end else begin
                out_ready_i = 1'b1;
            end
        end
    end

    // Input driver makes two passes over the table
    initial begin
        int wait_cyc;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        rs1_val_i  = '0;
        rs2_val_i  = '0;
        build_table();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < n_entries; i++) begin
                @(negedge clk_i);
                in_valid_i = 1'b1;
                instr_i    = tbl[i].instr;
                pc_i       = tbl[i].pc;
                rs1_val_i  = tbl[i].rs1;
                rs2_val_i  = tbl[i].rs2;
                #1;  // out_ready_i settles after the falling edge
                wait_cyc = 0;
                while (!in_ready_o) begin
                    @(negedge clk_i);
                    #1;
                    wait_cyc++;
                    if (wait_cyc > TIMEOUT) begin
                        $display("Timeout: in_ready_o stayed low for entry %0d", i);
                        $display("TB FAILED");
                        $finish;
                    end
                end
                accept_cycle[p*n_entries+i] = edge_cnt;  // Taken at the next rising edge
            end
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
    end

    // Results must arrive once each and in table order
    initial begin
        int     cyc;
        int     idx;
        int     extra;
        entry_t e;
        cyc = 0;
        while (rst_n_i !== 1'b1) begin
            @(negedge clk_i);
            #1;
            cyc++;
            if (cyc > TIMEOUT) begin
                $display("Timeout: reset was never released");
                $display("TB FAILED");
                $finish;
            end
        end
        for (int k = 0; k < 2 * n_entries; k++) begin
            idx = k % n_entries;
            e   = tbl[idx];
            cyc = 0;
            @(negedge clk_i);
            #1;
            while (!(out_valid_o && out_ready_i)) begin
                @(negedge clk_i);
                #1;
                cyc++;
                if (cyc > TIMEOUT) begin
                    $display("Timeout: no result for output %0d (entry %0d)", k, idx);
                    $display("TB FAILED");
                    $finish;
                end
            end
            if (k < n_entries) begin
                check_val(idx, "latency", 32'(edge_cnt - accept_cycle[k]), 32'd3);
            end
            check_val(idx, "rd_we", 32'(rd_we_o), 32'(e.rd_we));
            check_val(idx, "rd_wdata", rd_wdata_o, e.rd_wdata);
            check_val(idx, "br_taken", 32'(br_taken_o), 32'(e.br_taken));
            check_val(idx, "br_target", br_target_o, e.br_target);
            check_val(idx, "mem_req", 32'(mem_req_o), 32'(e.mem_req));
            check_val(idx, "mem_we", 32'(mem_we_o), 32'(e.mem_we));
            check_val(idx, "mem_addr", mem_addr_o, e.mem_addr);
            check_val(idx, "mem_wmask", 32'(mem_wmask_o), 32'(e.mem_wmask));
            check_val(idx, "mem_wdata", mem_wdata_o, e.mem_wdata);
            check_val(idx, "misaligned", 32'(misaligned_o), 32'(e.misaligned));
            check_val(idx, "illegal", 32'(illegal_o), 32'(e.illegal));
            if (k == n_entries - 1) begin
                bp_on = 1'b1;
            end
        end
        // Nothing may follow the last result
        extra = 0;
        repeat (10) begin
            @(negedge clk_i);
            #1;
            if (out_valid_o && out_ready_i) begin
                extra++;
            end
        end
        check_val(-1, "extra outputs", 32'(extra), 32'd0);
        $display("Summary: %0d outputs, %0d checks, %0d errors", 2 * n_entries, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
exu_pkg.sv
dec_if.sv
disp_if.sv
decode_stage.sv
dispatch_logic.sv
exec_stage.sv
exu_top.sv
tb_exu.sv

// File: run.sh
#!/bin/sh
# Build and run the execute pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exu -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_exu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
